// ==== hrdrst.f ====
source/hrdrst_cfg_pkg.sv
source/hrdrst_types_pkg.sv
source/hrdrst_rstsync.sv
source/hrdrst_reset_gen.sv
source/hrdrst_osc_sm.sv
source/hrdrst_rstctrl.sv
sim/hrdrst_assertions.sv
sim/hrdrst_checker.sv
sim/hrdrst_tb.sv

// ==== sim/hrdrst_tb.sv ====
/* Testbench for the hard-reset control top level, applies a stimulus table in a loop.
   Run with the project file list, top module hrdrst_tb. */
`default_nettype none

module hrdrst_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import hrdrst_types_pkg::*;

	localparam int         LIMIT    = 40;
	localparam logic [7:0] NO_ACK   = 8'hfe;
	localparam logic [7:0] RAND_ACK = 8'hff;

	logic cfg_avmm_clk, rst_clk_rx, rst_clk_tx, osc_clk_rx;
	logic cfg_avmm_rst_n, hard_rst_n, usermode_in, sr_fabric_osc_transfer_en;
	logic dft_adpt_rst, adapter_scan_rst_n, adapter_scan_mode_n;
	logic hard_rst_out_n, usermode_out, cfg_avmm_raw_rst_n, cfg_rst_n_sync;
	logic rx_rst_n, tx_rst_n, transfer_en, transfer_alive;
	testbus_t   testbus;
	tb_direct_t tb_direct;

	//************************************************************
	// Stimulus table
	//************************************************************
	// [18:14] scan_mode_n, dft_adpt_rst, scan_rst_n, hard_rst_n, usermode
	// [13:6] ack delay in cycles, [5:0] rx/tx rst, cfg rst, en, alive, state
	logic [18:0] rows [0:8];

	initial
	begin
		rows[0] = {5'b10111, 8'd3,     6'b111110}; // Release, enable, ack
		rows[1] = {5'b11110, NO_ACK,   6'b010000}; // DFT reset from ALIVE
		rows[2] = {5'b10111, RAND_ACK, 6'b111110};
		rows[3] = {5'b10100, NO_ACK,   6'b000000}; // Hard reset low
		rows[4] = {5'b10110, RAND_ACK, 6'b111110};
		rows[5] = {5'b00011, NO_ACK,   6'b000000}; // Scan mode, tester reset low
		rows[6] = {5'b00100, NO_ACK,   6'b111001}; // Scan release, no ack
		rows[7] = {5'b10100, NO_ACK,   6'b000000};
		rows[8] = {5'b10111, 8'd0,     6'b111110}; // Ack right after enable
	end

	// Three 4 ns clocks in phase
	// config clock offset off the drive points
	initial
	begin
		osc_clk_rx = 1'b0;
		forever #2 osc_clk_rx = ~osc_clk_rx;
	end

	initial
	begin
		rst_clk_rx = 1'b0;
		forever #2 rst_clk_rx = ~rst_clk_rx;
	end

	initial
	begin
		rst_clk_tx = 1'b0;
		forever #2 rst_clk_tx = ~rst_clk_tx;
	end

	initial
	begin
		cfg_avmm_clk = 1'b0;
		#1;
		forever #3 cfg_avmm_clk = ~cfg_avmm_clk;
	end

	hrdrst_rstctrl i_hrdrst_rstctrl
	(
		.cfg_avmm_rst_n (cfg_avmm_rst_n), .hard_rst_n (hard_rst_n), .usermode_in (usermode_in),
		.cfg_avmm_clk (cfg_avmm_clk),
		.avmm_clock_reset_hrdrst_rx_osc_clk (rst_clk_rx),
		.avmm_clock_reset_hrdrst_tx_osc_clk (rst_clk_tx),
		.avmm_clock_hrdrst_rx_osc_clk (osc_clk_rx),
		.sr_fabric_osc_transfer_en (sr_fabric_osc_transfer_en), .dft_adpt_rst (dft_adpt_rst),
		.adapter_scan_rst_n (adapter_scan_rst_n), .adapter_scan_mode_n (adapter_scan_mode_n),
		.hard_rst_out_n (hard_rst_out_n), .usermode_out (usermode_out),
		.cfg_avmm_raw_rst_n (cfg_avmm_raw_rst_n), .avmm_reset_cfg_avmm_rst_n (cfg_rst_n_sync),
		.avmm_reset_hrdrst_rx_osc_clk_rst_n (rx_rst_n),
		.avmm_reset_hrdrst_tx_osc_clk_rst_n (tx_rst_n),
		.avmm_hrdrst_hssi_osc_transfer_en (transfer_en),
		.avmm_hrdrst_hssi_osc_transfer_alive (transfer_alive),
		.avmm_hrdrst_testbus (testbus), .avmm_hrdrst_tb_direct (tb_direct)
	);

	hrdrst_checker i_checker
	(
		.hard_rst_n (hard_rst_n), .usermode_in (usermode_in), .cfg_avmm_rst_n (cfg_avmm_rst_n),
		.sr_fabric_osc_transfer_en (sr_fabric_osc_transfer_en),
		.hard_rst_out_n (hard_rst_out_n), .usermode_out (usermode_out),
		.cfg_avmm_raw_rst_n (cfg_avmm_raw_rst_n), .avmm_reset_cfg_avmm_rst_n (cfg_rst_n_sync),
		.avmm_reset_hrdrst_rx_osc_clk_rst_n (rx_rst_n),
		.avmm_reset_hrdrst_tx_osc_clk_rst_n (tx_rst_n),
		.avmm_hrdrst_hssi_osc_transfer_en (transfer_en),
		.avmm_hrdrst_hssi_osc_transfer_alive (transfer_alive),
		.avmm_hrdrst_testbus (testbus), .avmm_hrdrst_tb_direct (tb_direct)
	);

	// Level being waited for, by selector
	function automatic logic level_of(input int sel);
		case (sel)
			// Either domain reset, so an early release shows
			0:       level_of = rx_rst_n | tx_rst_n;
			1:       level_of = transfer_en;
			2:       level_of = (testbus[1:0] == OSC_TRANSFER_ALIVE);
			3:       level_of = transfer_alive;
			default: level_of = cfg_rst_n_sync;
		endcase
	endfunction

	// Counts RX osc edges until the level shows, gives up after LIMIT
	task automatic wait_level(input int sel, input logic lvl, input string what,
	                          output int edges);
		edges = 0;
		while (level_of(sel) !== lvl && edges < LIMIT)
		begin
			@(posedge osc_clk_rx);
			#1;
			edges++;
		end
		if (level_of(sel) !== lvl)
		begin
			$display("Timeout after %0d cycles waiting for %s", LIMIT, what);
			$display("Testbench failed");
			$finish;
		end
	endtask

	//************************************************************
	// Main sequence
	//************************************************************
	initial
	begin
		int edges;
		int dly;
		logic [18:0] r;
		void'($urandom(32'hb481_15b0));
		{adapter_scan_mode_n, dft_adpt_rst, adapter_scan_rst_n} = 3'b101;
		{hard_rst_n, cfg_avmm_rst_n, usermode_in, sr_fabric_osc_transfer_en} = 4'b0000;
		repeat (10) @(posedge osc_clk_rx);
		for (int i = 0; i < 9; i++)
		begin
			r = rows[i];
			@(posedge osc_clk_rx);
			#1;
			{adapter_scan_mode_n, dft_adpt_rst, adapter_scan_rst_n} = r[18:16];
			{hard_rst_n, usermode_in} = r[15:14];
			// Config reset follows the hard reset
			// but stays released in scan rows
			cfg_avmm_rst_n = r[15] | ~r[18];
			#0.5;
			// Assertion and scan bypass need no clock
			if (!r[5] || !r[18])
			begin
				i_checker.check_val("rx_rst_n", rx_rst_n, r[5]);
				i_checker.check_val("tx_rst_n", tx_rst_n, r[5]);
				i_checker.check_val("cfg_rst_n_sync", cfg_rst_n_sync, r[4]);
			end
			if (r[5])
			begin
				// Functional release takes two edges
				if (r[18])
				begin
					wait_level(0, 1'b1, "RX or TX reset release", edges);
					i_checker.check_val("rx reset release edges", edges, 2);
					i_checker.check_val("rx_rst_n", rx_rst_n, 1'b1);
					i_checker.check_val("tx_rst_n", tx_rst_n, 1'b1);
				end
				wait_level(1, 1'b1, "transfer enable", edges);
				i_checker.check_val("transfer_en edges", edges, 2);
				i_checker.check_val("testbus[1:0]", testbus[1:0], OSC_TRANSFER_EN);
				i_checker.check_val("transfer_alive", transfer_alive, 1'b0);
				// Config domain runs on its own clock
				if (r[18])
				begin
					wait_level(4, 1'b1, "config reset release", edges);
				end
				if (r[13:6] != NO_ACK)
				begin
					dly = (r[13:6] == RAND_ACK) ? ($urandom % 6) : r[13:6];
					repeat (dly) @(posedge osc_clk_rx);
					@(posedge osc_clk_rx);
					#1;
					sr_fabric_osc_transfer_en = 1'b1;
					wait_level(2, 1'b1, "ALIVE state", edges);
					i_checker.check_val("ALIVE state edges", edges, 1);
					wait_level(3, 1'b1, "transfer alive", edges);
					i_checker.check_val("transfer_alive edges", edges, 1);
					// Dropping the ack must not matter
					@(posedge osc_clk_rx);
					#1;
					sr_fabric_osc_transfer_en = 1'b0;
					repeat (2) @(posedge osc_clk_rx);
					#1;
				end
			end
			else
			begin
				wait_level(1, 1'b0, "FSM reset", edges);
			end
			i_checker.check_ports(r[5:0]);
			i_checker.end_row(i);
		end
		$display("Rows passed %0d, rows failed %0d, errors %0d",
		         i_checker.rows_passed, i_checker.rows_failed, i_checker.error_count);
		if (i_checker.error_count == 0 && i_checker.rows_failed == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : hrdrst_tb

`default_nettype wire

// ==== sim/hrdrst_checker.sv ====
/* Watches the DUT ports and compares them with expected values from the testbench.
   Keeps per-row and total error counts for the closing summary. */
`default_nettype none

module hrdrst_checker
	import hrdrst_types_pkg::*;
(
	input wire logic       hard_rst_n,
	input wire logic       usermode_in,
	input wire logic       cfg_avmm_rst_n,
	input wire logic       sr_fabric_osc_transfer_en,
	input wire logic       hard_rst_out_n,
	input wire logic       usermode_out,
	input wire logic       cfg_avmm_raw_rst_n,
	input wire logic       avmm_reset_cfg_avmm_rst_n,
	input wire logic       avmm_reset_hrdrst_rx_osc_clk_rst_n,
	input wire logic       avmm_reset_hrdrst_tx_osc_clk_rst_n,
	input wire logic       avmm_hrdrst_hssi_osc_transfer_en,
	input wire logic       avmm_hrdrst_hssi_osc_transfer_alive,
	input wire testbus_t   avmm_hrdrst_testbus,
	input wire tb_direct_t avmm_hrdrst_tb_direct
);
	timeunit 1ns;
	timeprecision 100ps;

	int error_count = 0;
	int row_errors  = 0;
	int rows_passed = 0;
	int rows_failed = 0;

	// Single value compare, X counts as a mismatch
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			error_count++;
			row_errors++;
		end
	endtask

	//************************************************************
	// Full port compare
	//************************************************************
	// exp holds {rx/tx reset, cfg reset, en, alive, state[1:0]}
	task automatic check_ports(input logic [5:0] exp);
		// Feedthroughs mirror the driven inputs
		check_val("hard_rst_out_n", hard_rst_out_n, hard_rst_n);
		check_val("usermode_out", usermode_out, usermode_in);
		check_val("cfg_avmm_raw_rst_n", cfg_avmm_raw_rst_n, cfg_avmm_rst_n);
		check_val("avmm_reset_hrdrst_rx_osc_clk_rst_n", avmm_reset_hrdrst_rx_osc_clk_rst_n, exp[5]);
		check_val("avmm_reset_hrdrst_tx_osc_clk_rst_n", avmm_reset_hrdrst_tx_osc_clk_rst_n, exp[5]);
		check_val("avmm_reset_cfg_avmm_rst_n", avmm_reset_cfg_avmm_rst_n, exp[4]);
		check_val("avmm_hrdrst_hssi_osc_transfer_en", avmm_hrdrst_hssi_osc_transfer_en, exp[3]);
		check_val("avmm_hrdrst_hssi_osc_transfer_alive", avmm_hrdrst_hssi_osc_transfer_alive,
		          exp[2]);
		// Packing: alive, en, live ack, state
		check_val("avmm_hrdrst_testbus", avmm_hrdrst_testbus,
		          {exp[2], exp[3], sr_fabric_osc_transfer_en, exp[1:0]});
		check_val("avmm_hrdrst_tb_direct", avmm_hrdrst_tb_direct, {exp[2], exp[1:0]});
	endtask

	// One line per finished row
	task automatic end_row(input int idx);
		if (row_errors == 0)
		begin
			rows_passed++;
			$display("Row %0d passed", idx);
		end
		else
		begin
			rows_failed++;
			$display("Row %0d failed with %0d errors", idx, row_errors);
		end
		row_errors = 0;
	endtask

endmodule : hrdrst_checker

`default_nettype wire

// ==== sim/hrdrst_assertions.sv ====
/* Concurrent checks on the oscillator-transfer FSM.
   Bound into every hrdrst_osc_sm instance. */
`default_nettype none

module hrdrst_assertions
	import hrdrst_types_pkg::*;
(
	input wire logic           clk,
	input wire logic           rst_n,
	input wire osc_rst_state_t state,
	input wire logic           transfer_en,
	input wire logic           transfer_alive
);
	timeunit 1ns;
	timeprecision 100ps;

	// Alive is only announced on top of enable
	alive_needs_en : assert property (@(posedge clk) disable iff (!rst_n)
		transfer_alive |-> transfer_en)
		else $error("transfer_alive high without transfer_en");

	// Encoding 3 is never entered
	no_illegal_state : assert property (@(posedge clk) disable iff (!rst_n)
		state != 2'd3)
		else $error("FSM state took the illegal encoding");

	// ALIVE is terminal while reset stays released
	alive_is_held : assert property (@(posedge clk)
		(state == OSC_TRANSFER_ALIVE && rst_n) |=> state == OSC_TRANSFER_ALIVE)
		else $error("FSM left ALIVE without a reset");

endmodule : hrdrst_assertions

bind hrdrst_osc_sm hrdrst_assertions i_hrdrst_assertions
(
	.clk            (avmm_clock_hrdrst_rx_osc_clk),
	.rst_n          (avmm_reset_hrdrst_rx_osc_clk_rst_n),
	.state          (osc_rst_sm_cs),
	.transfer_en    (avmm_hrdrst_hssi_osc_transfer_en),
	.transfer_alive (avmm_hrdrst_hssi_osc_transfer_alive)
);

`default_nettype wire

// ==== source/hrdrst_rstctrl.sv ====
/* Top level of the adapter hard-reset control, reset generation plus the oscillator
   transfer FSM, with the raw reset and user-mode feedthroughs. */
`default_nettype none

module hrdrst_rstctrl
	import hrdrst_types_pkg::*;
(
	input  logic       cfg_avmm_rst_n,
	input  logic       hard_rst_n,
	input  logic       usermode_in,
	input  logic       cfg_avmm_clk,
	input  logic       avmm_clock_reset_hrdrst_rx_osc_clk,
	input  logic       avmm_clock_reset_hrdrst_tx_osc_clk,
	input  logic       avmm_clock_hrdrst_rx_osc_clk,
	input  logic       sr_fabric_osc_transfer_en,
	input  logic       dft_adpt_rst,
	input  logic       adapter_scan_rst_n,
	input  logic       adapter_scan_mode_n,
	output logic       hard_rst_out_n,
	output logic       usermode_out,
	output logic       cfg_avmm_raw_rst_n,
	output logic       avmm_reset_cfg_avmm_rst_n,
	output logic       avmm_reset_hrdrst_rx_osc_clk_rst_n,
	output logic       avmm_reset_hrdrst_tx_osc_clk_rst_n,
	output logic       avmm_hrdrst_hssi_osc_transfer_en,
	output logic       avmm_hrdrst_hssi_osc_transfer_alive,
	output testbus_t   avmm_hrdrst_testbus,
	output tb_direct_t avmm_hrdrst_tb_direct
);

	//************************************************************
	// Feedthroughs
	//************************************************************
	// Unsynchronized copies for downstream blocks
	assign hard_rst_out_n     = hard_rst_n;
	assign usermode_out       = usermode_in;
	assign cfg_avmm_raw_rst_n = cfg_avmm_rst_n;

	//************************************************************
	// Reset generation
	//************************************************************
	hrdrst_reset_gen i_hrdrst_reset_gen
	(
		.hard_rst_n                         (hard_rst_n),
		.cfg_avmm_rst_n                     (cfg_avmm_rst_n),
		.dft_adpt_rst                       (dft_adpt_rst),
		.adapter_scan_rst_n                 (adapter_scan_rst_n),
		.adapter_scan_mode_n                (adapter_scan_mode_n),
		.avmm_clock_reset_hrdrst_rx_osc_clk (avmm_clock_reset_hrdrst_rx_osc_clk),
		.avmm_clock_reset_hrdrst_tx_osc_clk (avmm_clock_reset_hrdrst_tx_osc_clk),
		.cfg_avmm_clk                       (cfg_avmm_clk),
		.avmm_reset_hrdrst_rx_osc_clk_rst_n (avmm_reset_hrdrst_rx_osc_clk_rst_n),
		.avmm_reset_hrdrst_tx_osc_clk_rst_n (avmm_reset_hrdrst_tx_osc_clk_rst_n),
		.avmm_reset_cfg_avmm_rst_n          (avmm_reset_cfg_avmm_rst_n)
	);

	//************************************************************
	// Oscillator-transfer FSM
	//************************************************************
	// Runs on the RX osc clock
	// reset is the synchronized RX domain reset
	hrdrst_osc_sm i_hrdrst_osc_sm
	(
		.avmm_clock_hrdrst_rx_osc_clk        (avmm_clock_hrdrst_rx_osc_clk),
		.avmm_reset_hrdrst_rx_osc_clk_rst_n  (avmm_reset_hrdrst_rx_osc_clk_rst_n),
		.sr_fabric_osc_transfer_en           (sr_fabric_osc_transfer_en),
		.avmm_hrdrst_hssi_osc_transfer_en    (avmm_hrdrst_hssi_osc_transfer_en),
		.avmm_hrdrst_hssi_osc_transfer_alive (avmm_hrdrst_hssi_osc_transfer_alive),
		.avmm_hrdrst_testbus                 (avmm_hrdrst_testbus),
		.avmm_hrdrst_tb_direct               (avmm_hrdrst_tb_direct)
	);

endmodule : hrdrst_rstctrl

`default_nettype wire

// ==== source/hrdrst_osc_sm.sv ====
/* Oscillator-transfer FSM in the RX oscillator domain, announces enable then alive
   once the fabric acknowledges. Also packs the test bus and direct test port. */
`default_nettype none

module hrdrst_osc_sm
	import hrdrst_types_pkg::*;
(
	input  logic       avmm_clock_hrdrst_rx_osc_clk,
	input  logic       avmm_reset_hrdrst_rx_osc_clk_rst_n,
	input  logic       sr_fabric_osc_transfer_en,
	output logic       avmm_hrdrst_hssi_osc_transfer_en,
	output logic       avmm_hrdrst_hssi_osc_transfer_alive,
	output testbus_t   avmm_hrdrst_testbus,
	output tb_direct_t avmm_hrdrst_tb_direct
);

	//************************************************************
	// State and next-state signals
	//************************************************************
	osc_rst_state_t osc_rst_sm_cs;
	osc_rst_state_t osc_rst_sm_ns;

	// Output values decoded from current state
	logic transfer_en_comb;
	logic transfer_alive_comb;

	//************************************************************
	// State register
	//************************************************************
	always_ff @(posedge avmm_clock_hrdrst_rx_osc_clk)
	begin
		if (!avmm_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			osc_rst_sm_cs <= WAIT_RX_OSC_CLK_READY;
		end
		else
		begin
			osc_rst_sm_cs <= osc_rst_sm_ns;
		end
	end

	//************************************************************
	// Next state and output decode
	//************************************************************
	always_comb
	begin
		// Hold state, outputs low
		osc_rst_sm_ns       = osc_rst_sm_cs;
		transfer_en_comb    = 1'b0;
		transfer_alive_comb = 1'b0;

		case (osc_rst_sm_cs)
			// RX osc clock running once reset has released
			WAIT_RX_OSC_CLK_READY:
			begin
				osc_rst_sm_ns = OSC_TRANSFER_EN;
			end

			// Enable announced, wait for fabric ack level
			OSC_TRANSFER_EN:
			begin
				transfer_en_comb = 1'b1;
				if (sr_fabric_osc_transfer_en)
				begin
					osc_rst_sm_ns = OSC_TRANSFER_ALIVE;
				end
			end

			// Terminal until next reset
			// ack dropping is ignored
			OSC_TRANSFER_ALIVE:
			begin
				transfer_en_comb    = 1'b1;
				transfer_alive_comb = 1'b1;
			end

			// Illegal encoding, back to WAIT
			default:
			begin
				osc_rst_sm_ns       = WAIT_RX_OSC_CLK_READY;
				transfer_en_comb    = 1'b0;
				transfer_alive_comb = 1'b0;
			end
		endcase
	end

	//************************************************************
	// Registered outputs
	//************************************************************
	// One edge behind the state
	always_ff @(posedge avmm_clock_hrdrst_rx_osc_clk)
	begin
		if (!avmm_reset_hrdrst_rx_osc_clk_rst_n)
		begin
			avmm_hrdrst_hssi_osc_transfer_en    <= 1'b0;
			avmm_hrdrst_hssi_osc_transfer_alive <= 1'b0;
		end
		else
		begin
			avmm_hrdrst_hssi_osc_transfer_en    <= transfer_en_comb;
			avmm_hrdrst_hssi_osc_transfer_alive <= transfer_alive_comb;
		end
	end

	//************************************************************
	// Test ports
	//************************************************************
	// Live ack and current state, no delay
	assign avmm_hrdrst_testbus = {avmm_hrdrst_hssi_osc_transfer_alive,
	                              avmm_hrdrst_hssi_osc_transfer_en,
	                              sr_fabric_osc_transfer_en,
	                              osc_rst_sm_cs};

	// Alive flag and state only
	assign avmm_hrdrst_tb_direct = {avmm_hrdrst_hssi_osc_transfer_alive, osc_rst_sm_cs};

endmodule : hrdrst_osc_sm

`default_nettype wire

// ==== source/hrdrst_reset_gen.sv ====
/* Qualifies the hard reset with scan and DFT controls and synchronizes it into
   the RX and TX oscillator domains, plus the config reset into the config clock. */
`default_nettype none

module hrdrst_reset_gen
(
	input  logic hard_rst_n,
	input  logic cfg_avmm_rst_n,
	input  logic dft_adpt_rst,
	input  logic adapter_scan_rst_n,
	input  logic adapter_scan_mode_n,
	input  logic avmm_clock_reset_hrdrst_rx_osc_clk,
	input  logic avmm_clock_reset_hrdrst_tx_osc_clk,
	input  logic cfg_avmm_clk,
	output logic avmm_reset_hrdrst_rx_osc_clk_rst_n,
	output logic avmm_reset_hrdrst_tx_osc_clk_rst_n,
	output logic avmm_reset_cfg_avmm_rst_n
);

	//************************************************************
	// Hard reset qualification
	//************************************************************
	// Combined hard reset before synchronization
	logic hrd_rst_n_qual;

	// Functional mode, DFT reset forces assertion
	// scan mode, tester reset only
	always_comb
	begin
		if (adapter_scan_mode_n)
		begin
			hrd_rst_n_qual = hard_rst_n & ~dft_adpt_rst;
		end
		else
		begin
			hrd_rst_n_qual = adapter_scan_rst_n;
		end
	end

	//************************************************************
	// Domain synchronizers
	//************************************************************
	// RX oscillator domain, also resets the FSM
	hrdrst_rstsync i_rstsync_rx_osc
	(
		.clk          (avmm_clock_reset_hrdrst_rx_osc_clk),
		.rst_n        (hrd_rst_n_qual),
		.rst_n_bypass (adapter_scan_rst_n),
		.scan_mode_n  (adapter_scan_mode_n),
		.rst_n_sync   (avmm_reset_hrdrst_rx_osc_clk_rst_n)
	);

	// TX oscillator domain
	hrdrst_rstsync i_rstsync_tx_osc
	(
		.clk          (avmm_clock_reset_hrdrst_tx_osc_clk),
		.rst_n        (hrd_rst_n_qual),
		.rst_n_bypass (adapter_scan_rst_n),
		.scan_mode_n  (adapter_scan_mode_n),
		.rst_n_sync   (avmm_reset_hrdrst_tx_osc_clk_rst_n)
	);

	// Config bus domain
	// Raw config reset, not the hard reset
	hrdrst_rstsync i_rstsync_cfg_avmm
	(
		.clk          (cfg_avmm_clk),
		.rst_n        (cfg_avmm_rst_n),
		.rst_n_bypass (adapter_scan_rst_n),
		.scan_mode_n  (adapter_scan_mode_n),
		.rst_n_sync   (avmm_reset_cfg_avmm_rst_n)
	);

endmodule : hrdrst_reset_gen

`default_nettype wire

// ==== source/hrdrst_rstsync.sv ====
/* Active-low reset synchronizer, asserts at once and releases on the destination clock.
   Scan mode hands the output straight to the bypass reset. */
`default_nettype none

module hrdrst_rstsync
	import hrdrst_cfg_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic rst_n_bypass,
	input  logic scan_mode_n,
	output logic rst_n_sync
);

	//************************************************************
	// Synchronizer chain
	//************************************************************
	// Stage 0 samples the constant one
	// last stage drives the domain reset
	logic [RSTSYNC_STAGES-1:0] sync_q;

	// Asynchronous clear, ones shift in after release
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q <= '0;
		end
		else
		begin
			sync_q <= {sync_q[RSTSYNC_STAGES-2:0], 1'b1};
		end
	end

	//************************************************************
	// Scan bypass
	//************************************************************
	// Tester owns the reset in scan mode
	// no flop in this path
	always_comb
	begin
		if (scan_mode_n)
		begin
			rst_n_sync = sync_q[RSTSYNC_STAGES-1];
		end
		else
		begin
			rst_n_sync = rst_n_bypass;
		end
	end

endmodule : hrdrst_rstsync

`default_nettype wire

// ==== source/hrdrst_types_pkg.sv ====
/* State encoding of the oscillator-transfer FSM and typed test-port vectors.
   Imported by the FSM, the top level and the verification files. */
`default_nettype none

package hrdrst_types_pkg;

	import hrdrst_cfg_pkg::*;

	//************************************************************
	// Oscillator-transfer FSM
	//************************************************************
	// Encoding 2'd3 is never entered
	// FSM recovers to WAIT if it is seen
	typedef enum logic [1:0]
	{
		WAIT_RX_OSC_CLK_READY = 2'd0,
		OSC_TRANSFER_EN       = 2'd1,
		OSC_TRANSFER_ALIVE    = 2'd2
	} osc_rst_state_t;

	//************************************************************
	// Test ports
	//************************************************************
	// {alive, en, fabric ack, state}
	typedef logic [TESTBUS_W-1:0] testbus_t;

	// {alive, state}
	typedef logic [TB_DIRECT_W-1:0] tb_direct_t;

endpackage : hrdrst_types_pkg

`default_nettype wire

// ==== source/hrdrst_cfg_pkg.sv ====
/* Sizing constants for the hard-reset control block.
   Imported wherever a synchronizer depth or a test-port width is needed. */
`default_nettype none

package hrdrst_cfg_pkg;

	//************************************************************
	// Reset synchronizers
	//************************************************************
	// Flops per chain, shared by RX, TX and config domains
	localparam int RSTSYNC_STAGES = 2;

	//************************************************************
	// Test ports
	//************************************************************
	// Full test bus
	// alive, enable, fabric ack, state[1:0]
	localparam int TESTBUS_W = 5;

	// Direct test port
	// alive, state[1:0]
	localparam int TB_DIRECT_W = 3;

endpackage : hrdrst_cfg_pkg

`default_nettype wire
